// File: build.f
source/spi_cfg_pkg.sv
source/spi_cmd_pkg.sv
source/spi_fe.sv
source/spi_cmd_ctrl.sv
source/spi_reg_bank.sv
source/spi_slave_top.sv
tb/tb_clk_gen.sv
tb/spi_slave_props.sv
tb/tb_spi_slave.sv

// File: source/spi_cfg_pkg.sv
`default_nettype none

package spi_cfg_pkg;

  // word and register address widths
  localparam int DATA_W_DEF = 8;   // bits per spi word
  localparam int ADDR_W_DEF = 4;   // 16 registers

  // The structs below are sized by the defaults above, so any top level that
  // instantiates the slave must keep DATA_W == DATA_W_DEF and
  // ADDR_W == ADDR_W_DEF.

  // register write event, one clk strobe with address and data
  typedef struct packed {
    logic                  valid;  // write strobe
    logic [ADDR_W_DEF-1:0] addr;   // target register
    logic [DATA_W_DEF-1:0] data;   // value written
  } reg_wr_t;

  // front end report towards the command controller
  typedef struct packed {
    logic                  word_done;    // full word shifted in
    logic                  frame_start;  // ss went low
    logic                  frame_end;    // ss went high
    logic [DATA_W_DEF-1:0] rx_word;      // last bits from mosi, msb first
  } fe_word_t;

endpackage

`default_nettype wire

// File: source/spi_cmd_ctrl.sv
`default_nettype none

module spi_cmd_ctrl
  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire fe_word_t          fe,       // from front end
  input  wire logic [DATA_W-1:0] rd_data,  // bank read port
  output logic [DATA_W-1:0]      tx_word,  // next word for miso
  output logic [ADDR_W-1:0]      rd_addr,
  output reg_wr_t                wr        // write event
);

  cmd_state_e        state;
  spi_op_e           op_q;       // opcode of current frame
  cmd_word_t         cmd;        // rx word seen as command
  logic [ADDR_W-1:0] addr_q;     // burst address counter
  logic [DATA_W-1:0] wr_cnt;     // completed writes, wraps
  logic              ld_tx;      // refresh tx_word next clk
  logic              wr_vld;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [DATA_W-1:0] wr_data_q;
  logic              cmd_done;   // command word complete
  logic              data_done;  // data word complete
  logic              is_write;
  logic              burst_op;   // opcode that needs data phase

  assign cmd       = fe.rx_word;
  assign cmd_done  = fe.word_done & (state == ST_CMD);
  assign data_done = fe.word_done & (state == ST_DATA);
  assign is_write  = (op_q == OP_WRITE);

  // nop and reserved opcodes skip to drain
  always_comb begin
    case (cmd.op)
      OP_WRITE, OP_READ: burst_op = 1'b1;
      OP_NOP, OP_RSVD:   burst_op = 1'b0;
      default:           burst_op = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= ST_IDLE;
      op_q   <= OP_NOP;
      addr_q <= '0;
      wr_cnt <= '0;
      ld_tx  <= 1'b0;
      wr_vld <= 1'b0;
    end else begin
      ld_tx  <= 1'b0;  // one clk pulses
      wr_vld <= 1'b0;
      if (fe.frame_end) begin
        state <= ST_IDLE;  // partial word dropped here
      end else if (fe.frame_start) begin
        state <= ST_CMD;
      end else if (cmd_done) begin
        op_q   <= cmd.op;
        addr_q <= cmd.addr;
        ld_tx  <= 1'b1;  // first read word or zero
        state  <= burst_op ? ST_DATA : ST_DRAIN;
      end else if (data_done) begin
        wr_vld <= is_write;
        if (is_write) wr_cnt <= wr_cnt + 1'b1;  // same clk as strobe
        addr_q <= addr_q + 1'b1;                // wraps at 2**ADDR_W
        ld_tx  <= 1'b1;
      end
    end
  end

  // write payload taken with the strobe
  always_ff @(posedge clk) begin
    if (data_done) begin
      wr_addr_q <= addr_q;
      wr_data_q <= fe.rx_word;
    end
  end

  // transmit word, status first then burst data
  always_ff @(posedge clk) begin
    if (fe.frame_start) tx_word <= wr_cnt;                               // status word
    else if (ld_tx) tx_word <= (op_q == OP_READ) ? rd_data : '0;  // read data or idle
  end

  assign rd_addr = addr_q;  // combinational bank lookup
  assign wr      = '{valid: wr_vld, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire

// File: source/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

  import spi_cfg_pkg::*;

  // opcode in the top two bits of the command word
  typedef enum logic [1:0] {
    OP_NOP   = 2'b00,  // data slots idle, read as zero
    OP_WRITE = 2'b01,  // data words go to registers
    OP_READ  = 2'b10,  // data slots return registers
    OP_RSVD  = 2'b11   // handled as nop
  } spi_op_e;

  // command controller states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,  // ss high
    ST_CMD   = 2'b01,  // first word of frame pending
    ST_DATA  = 2'b10,  // read or write burst
    ST_DRAIN = 2'b11   // rest of frame ignored
  } cmd_state_e;

  // bits between opcode and start address carry nothing
  localparam int CMD_PAD_W = DATA_W_DEF - ADDR_W_DEF - 2;

  // command word as it arrives on mosi
  typedef struct packed {
    spi_op_e               op;    // msb pair
    logic [CMD_PAD_W-1:0]  pad;   // don't care
    logic [ADDR_W_DEF-1:0] addr;  // burst start address
  } cmd_word_t;

endpackage

`default_nettype wire

// File: source/spi_fe.sv
`default_nettype none

module spi_fe
  import spi_cfg_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              sclk,     // serial clock from master
  input  wire logic              ss,       // active low slave select
  input  wire logic              mosi,
  input  wire logic [DATA_W-1:0] tx_word,  // word to shift out
  output logic                   miso,
  output fe_word_t               fe        // strobes and received word
);

  localparam int CNT_W = $clog2(DATA_W);
  localparam logic [DATA_W-1:0] TX_MSB = {1'b1, {(DATA_W-1){1'b0}}};  // one-hot msb

  logic [2:0]        sclk_hist;   // sclk sampler with [2] oldest
  logic [2:0]        ss_hist;     // ss sampler
  logic [2:0]        mosi_hist;   // mosi sampler read at [2]
  logic              sclk_rise;
  logic              sclk_fall;
  logic              ss_fall;
  logic              ss_rise;
  logic              ss_act;      // frame in progress
  logic [CNT_W-1:0]  bit_cnt;     // bits of current word so far
  logic [DATA_W-1:0] rx_sr;       // mosi shift register
  logic [DATA_W-1:0] tx_ptr;      // one-hot bit select on tx_word
  logic              tx_hold;     // first rising edge of a word keeps msb
  logic              done_q;
  logic              start_q;
  logic              end_q;

  assign sclk_rise = ~sclk_hist[2] & sclk_hist[1];  // rising edge seen
  assign sclk_fall = sclk_hist[2] & ~sclk_hist[1];  // falling edge seen
  assign ss_fall   = ss_hist[2] & ~ss_hist[1];
  assign ss_rise   = ~ss_hist[2] & ss_hist[1];
  assign ss_act    = ~ss_hist[1];                   // aligned with sclk_hist[1]

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_hist <= 3'b000;  // sclk idles low
      ss_hist   <= 3'b111;  // deselected
    end else begin
      sclk_hist <= {sclk_hist[1:0], sclk};
      ss_hist   <= {ss_hist[1:0], ss};
    end
  end

  // mosi_hist[2] was taken with sclk_hist[2], the last high sample
  always_ff @(posedge clk) begin
    mosi_hist <= {mosi_hist[1:0], mosi};
    if (ss_act && sclk_fall) rx_sr <= {rx_sr[DATA_W-2:0], mosi_hist[2]};  // msb first
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
      done_q  <= 1'b0;
      start_q <= 1'b0;
      end_q   <= 1'b0;
    end else begin
      done_q  <= ss_act & sclk_fall & (bit_cnt == CNT_W'(DATA_W - 1));  // last bit in
      start_q <= ss_fall;
      end_q   <= ss_rise;
      if (ss_fall) bit_cnt <= '0;                                       // new frame
      else if (ss_act && sclk_fall) begin
        if (bit_cnt == CNT_W'(DATA_W - 1)) bit_cnt <= '0;               // word boundary
        else bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // word boundary load wins over pointer shift
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_ptr  <= '0;  // keeps miso low
      tx_hold <= 1'b0;
    end else if (start_q || done_q) begin
      tx_ptr  <= TX_MSB;
      tx_hold <= 1'b1;
    end else if (ss_act && sclk_rise) begin
      if (tx_hold) tx_hold <= 1'b0;  // msb already on the pin
      else tx_ptr <= tx_ptr >> 1;
    end
  end

  assign miso = |(tx_ptr & tx_word);  // selected bit

  assign fe = '{word_done: done_q, frame_start: start_q, frame_end: end_q, rx_word: rx_sr};

endmodule

`default_nettype wire

// File: source/spi_reg_bank.sv
`default_nettype none

module spi_reg_bank
  import spi_cfg_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire reg_wr_t           wr,       // write event from controller
  input  wire logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0]      rd_data
);

  localparam int NUM_REGS = 2 ** ADDR_W;  // full address space

  logic [DATA_W-1:0] regs [NUM_REGS];     // control registers

  // write lands on the edge that samples valid
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;  // registers start cleared
      end
    end else if (wr.valid) begin
      regs[wr.addr] <= wr.data;
    end
  end

  assign rd_data = regs[rd_addr];  // async read

endmodule

`default_nettype wire

// File: source/spi_slave_top.sv
`default_nettype none

module spi_slave_top
  import spi_cfg_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF,  // keep equal to package default
  parameter int ADDR_W = ADDR_W_DEF   // keep equal to package default
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic sclk,
  input  wire logic ss,
  input  wire logic mosi,
  output logic      miso,
  output reg_wr_t   wr_evt   // register write strobe with addr and data
);

  fe_word_t          fe_w;     // front end strobes and rx word
  logic [DATA_W-1:0] tx_word;  // controller to shifter
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;

  spi_fe #(
    .DATA_W (DATA_W)
  ) u_fe (
    .clk     (clk),
    .rst     (rst),
    .sclk    (sclk),
    .ss      (ss),
    .mosi    (mosi),
    .tx_word (tx_word),
    .miso    (miso),
    .fe      (fe_w)
  );

  spi_cmd_ctrl #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_ctrl (
    .clk     (clk),
    .rst     (rst),
    .fe      (fe_w),
    .rd_data (rd_data),
    .tx_word (tx_word),
    .rd_addr (rd_addr),
    .wr      (wr_evt)    // also feeds the bank
  );

  spi_reg_bank #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_bank (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr_evt),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: tb/spi_slave_props.sv
`default_nettype none

module spi_slave_props
  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;
(
  input wire logic       clk,
  input wire logic       rst,
  input wire fe_word_t   fe,     // front end strobes
  input wire reg_wr_t    wr,     // write event out of controller
  input wire cmd_state_e state,
  input wire spi_op_e    op_q    // latched opcode
);

  int fail_cnt = 0;  // failed property count

  // write strobe is a single clk pulse
  a_wr_single: assert property (@(posedge clk) disable iff (rst) wr.valid |=> !wr.valid)
    else begin
      $error("write strobe held longer than one clk");
      fail_cnt = fail_cnt + 1;
    end

  // writes only come out of a write burst
  a_wr_legal: assert property (@(posedge clk) disable iff (rst)
    wr.valid |-> (state == ST_DATA && op_q == OP_WRITE))
    else begin
      $error("write strobe outside a write burst");
      fail_cnt = fail_cnt + 1;
    end

  // ss rising always ends the frame
  a_end_idle: assert property (@(posedge clk) disable iff (rst) fe.frame_end |=> state == ST_IDLE)
    else begin
      $error("controller not idle after frame end");
      fail_cnt = fail_cnt + 1;
    end

  // idle is left only through frame_start
  a_idle_hold: assert property (@(posedge clk) disable iff (rst)
    (state == ST_IDLE && !fe.frame_start) |=> state == ST_IDLE)
    else begin
      $error("controller left idle without frame start");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind spi_cmd_ctrl spi_slave_props u_props (
  .clk   (clk),
  .rst   (rst),
  .fe    (fe),
  .wr    (wr),
  .state (state),
  .op_q  (op_q)
);

`default_nettype wire

// File: tb/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 8  // clk period in time units
) (
  output logic clk
);

  initial clk = 1'b0;                // known level at time zero
  always #(PERIOD / 2) clk = ~clk;  // free running

endmodule

`default_nettype wire

// File: tb/tb_spi_slave.sv
`default_nettype none

module tb_spi_slave
  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 8;
  localparam int SCLK_HALF  = 8;   // clk per sclk half period
  localparam int NUM_FRAMES = 14;  // frames issued by the sequence below
  localparam int MAX_WORDS  = 6;   // command plus 5 data words
  localparam int WD_TIME    = NUM_FRAMES * MAX_WORDS * DATA_W_DEF * 2 * SCLK_HALF
                              * CLK_PERIOD * 2;  // doubled for margin

  logic    clk;
  logic    rst;
  logic    sclk;
  logic    ss;
  logic    mosi;
  logic    miso;
  reg_wr_t wr_evt;

  logic [DATA_W_DEF-1:0] model_regs [2**ADDR_W_DEF];  // expected register contents
  logic [DATA_W_DEF-1:0] model_cnt;                   // expected status word
  reg_wr_t               exp_q [$];                   // writes still to be seen
  reg_wr_t               exp_ev;
  logic [31:0]           rng;                         // xorshift state
  logic [DATA_W_DEF-1:0] tx_buf  [MAX_WORDS];
  logic [DATA_W_DEF-1:0] rx_buf  [MAX_WORDS];
  logic [DATA_W_DEF-1:0] exp_buf [MAX_WORDS];

  tb_clk_gen #(.PERIOD (CLK_PERIOD)) u_clk (.clk (clk));

  spi_slave_top #(
    .DATA_W (DATA_W_DEF),
    .ADDR_W (ADDR_W_DEF)
  ) u_dut (
    .clk    (clk),
    .rst    (rst),
    .sclk   (sclk),
    .ss     (ss),
    .mosi   (mosi),
    .miso   (miso),
    .wr_evt (wr_evt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);  // advance shared state
    return rng;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    abort_run($sformatf("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h",
                        $time, name, exp, act));
  endtask

  // one word msb first with mosi set on sclk rise and miso read before fall
  task automatic shift_word(input logic [DATA_W_DEF-1:0] w, input int nbits,
                            output logic [DATA_W_DEF-1:0] r);
    r = '0;
    for (int i = DATA_W_DEF - 1; i >= DATA_W_DEF - nbits; i--) begin
      @(negedge clk);
      sclk = 1'b1;
      mosi = w[i];
      repeat (SCLK_HALF - 1) @(negedge clk);
      @(negedge clk);
      r[i] = miso;  // sampled at end of high phase
      sclk = 1'b0;
      repeat (SCLK_HALF - 1) @(negedge clk);
    end
  endtask

  // command word, n_data data words and an optional cut word of cut_bits bits
  task automatic run_frame(input spi_op_e op, input logic [ADDR_W_DEF-1:0] addr,
                           input int n_data, input int cut_bits);
    cmd_word_t             cmd;
    logic [ADDR_W_DEF-1:0] a;
    logic [31:0]           rnd;
    logic [DATA_W_DEF-1:0] part_tx;
    logic [DATA_W_DEF-1:0] part_rx;
    reg_wr_t               ev;
    cmd.op     = op;
    cmd.pad    = '0;
    cmd.addr   = addr;
    tx_buf[0]  = cmd;
    exp_buf[0] = model_cnt;  // status shifted out during command
    a = addr;
    for (int j = 1; j <= n_data; j++) begin
      rnd        = next_rand();
      tx_buf[j]  = rnd[DATA_W_DEF-1:0];
      exp_buf[j] = (op == OP_READ) ? model_regs[a] : '0;  // read data or idle zero
      if (op == OP_WRITE) begin
        ev.valid = 1'b1;
        ev.addr  = a;
        ev.data  = tx_buf[j];
        exp_q.push_back(ev);
        model_regs[a] = tx_buf[j];
        model_cnt     = model_cnt + 1'b1;  // wraps like the status counter
      end
      a = a + 1'b1;  // address wraps at top of map
    end
    rnd     = next_rand();
    part_tx = rnd[DATA_W_DEF-1:0];
    @(negedge clk);
    ss = 1'b0;
    repeat (SCLK_HALF) @(negedge clk);  // lets status word reach miso
    for (int j = 0; j <= n_data; j++) begin
      shift_word(tx_buf[j], DATA_W_DEF, rx_buf[j]);
    end
    if (cut_bits > 0) shift_word(part_tx, cut_bits, part_rx);  // dropped by slave
    repeat (SCLK_HALF) @(negedge clk);
    ss   = 1'b1;
    mosi = 1'b0;
    repeat (2 * SCLK_HALF) @(negedge clk);  // inter frame gap
    for (int j = 0; j <= n_data; j++) begin
      assert (rx_buf[j] == exp_buf[j])
        else report_mismatch($sformatf("miso word %0d", j), exp_buf[j], rx_buf[j]);
    end
    assert (exp_q.size() == 0)
      else abort_run("expected wr_evt strobe did not appear before frame end");
  endtask

  // every wr_evt strobe must match the next expected write
  always @(negedge clk) begin
    if (!rst && wr_evt.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("wr_evt strobe seen while no register write was expected");
      end else begin
        exp_ev = exp_q.pop_front();
        assert (wr_evt.addr == exp_ev.addr)
          else report_mismatch("wr_evt.addr", exp_ev.addr, wr_evt.addr);
        assert (wr_evt.data == exp_ev.data)
          else report_mismatch("wr_evt.data", exp_ev.data, wr_evt.data);
      end
    end
  end

  // bound controller properties end the run at their first failure
  always @(u_dut.u_ctrl.u_props.fail_cnt) begin
    if (u_dut.u_ctrl.u_props.fail_cnt != 0) begin
      abort_run("controller property assertion failed during the run");
    end
  end

  initial begin : watchdog
    #(WD_TIME);
    abort_run("timeout, test sequence did not complete in time");
  end

  initial begin : main_seq
    logic [31:0]           rnd;
    logic [ADDR_W_DEF-1:0] a;
    rst       = 1'b1;
    ss        = 1'b1;  // deselected
    sclk      = 1'b0;  // idle low
    mosi      = 1'b0;
    rng       = 32'd13;
    model_cnt = '0;
    for (int i = 0; i < 2**ADDR_W_DEF; i++) model_regs[i] = '0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);

    run_frame(OP_READ, 4'd0, 2, 0);  // registers and status clear after reset

    for (int k = 0; k < 3; k++) begin  // single write, then read back
      rnd = next_rand();
      a   = rnd[ADDR_W_DEF-1:0];
      run_frame(OP_WRITE, a, 1, 0);
      run_frame(OP_READ, a, 1, 0);
    end

    run_frame(OP_WRITE, 4'd14, 5, 0);  // burst across 15 -> 0
    run_frame(OP_READ, 4'd14, 5, 0);

    run_frame(OP_NOP, 4'd2, 3, 0);   // zeros out and no writes
    run_frame(OP_RSVD, 4'd2, 3, 0);
    run_frame(OP_READ, 4'd2, 3, 0);  // range untouched

    run_frame(OP_WRITE, 4'd6, 1, 5);  // ss rises inside second data word
    run_frame(OP_READ, 4'd6, 2, 0);   // reg 7 keeps old value

    if (u_dut.u_ctrl.u_props.fail_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("controller property assertion failed during the run");
    end
  end

endmodule

`default_nettype wire
